//--- sdram_emu_settings.svh
// Build-time settings of the SDRAM emulation slave
//   Bus data and byte address widths
//   Wait states per OKAY data phase
//   SDRAM bank and column split of the word address
//   Byte address window watched by the access monitor

`ifndef SDRAM_EMU_SETTINGS_SVH
`define SDRAM_EMU_SETTINGS_SVH

// AHB-Lite data bus width
`define SDRAM_EMU_DATA_W 32
// Byte address width, 4 KiB of storage
`define SDRAM_EMU_HADDR_W 12

// Wait states inserted into every OKAY data phase
`define SDRAM_EMU_WAIT 3

// Bank bits sit at the top of the word address
`define SDRAM_EMU_BANK_W 2
`define SDRAM_EMU_COL_W 6

// Monitor window, base inclusive, limit exclusive
`define SDRAM_EMU_WIN_BASE 'h400
`define SDRAM_EMU_WIN_LIMIT 'hC00

`endif

//--- sdram_emu_pkg.sv
// Shared types of the SDRAM emulation slave
//   Derived widths
//   AHB-Lite transfer type and size encodings
//   Request and response bundles
//   Bank/row/col view of the word address
//   Captured data phase and monitor record

`include "sdram_emu_settings.svh"

`default_nettype none

package sdram_emu_pkg;

  // Byte lanes per bus word
  localparam int BE_W      = `SDRAM_EMU_DATA_W / 8;
  // Word address, byte offset removed
  localparam int WADDR_W   = `SDRAM_EMU_HADDR_W - 2;
  // Whatever is left between bank and column
  localparam int ROW_W     = WADDR_W - `SDRAM_EMU_BANK_W - `SDRAM_EMU_COL_W;
  // Monitor counter width
  localparam int MON_CNT_W = 16;

  ////////////////////////////////////////
  // Bus encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // Sizes up to the bus width only
  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_e;

  // Address phase signals from the master
  typedef struct packed {
    logic                          hsel;
    logic [`SDRAM_EMU_HADDR_W-1:0] haddr;
    logic                          hwrite;
    hsize_e                        hsize;
    htrans_e                       htrans;
    logic                          hready;
  } ahb_req_t;

  // Slave response
  typedef struct packed {
    logic [`SDRAM_EMU_DATA_W-1:0] hrdata;
    logic                         hreadyout;
    logic                         hresp;
  } ahb_rsp_t;

  ////////////////////////////////////////
  // SDRAM address view
  ////////////////////////////////////////

  // Bank in the MSBs, as on the real part
  typedef struct packed {
    logic [`SDRAM_EMU_BANK_W-1:0] bank;
    logic [ROW_W-1:0]             row;
    logic [`SDRAM_EMU_COL_W-1:0]  col;
  } sdram_brc_t;

  // Same word address, linear or split
  typedef union packed {
    logic [WADDR_W-1:0] linear;
    sdram_brc_t         brc;
  } sdram_addr_u;

  ////////////////////////////////////////
  // Internal records
  ////////////////////////////////////////

  // Transfer held for its data phase
  typedef struct packed {
    logic                          valid;
    logic                          write;
    logic                          misaligned;
    logic [BE_W-1:0]               be;
    logic [WADDR_W-1:0]            idx;
    logic [`SDRAM_EMU_HADDR_W-1:0] addr;
    hsize_e                        size;
  } dphase_t;

  // Last access seen inside the monitor window
  typedef struct packed {
    logic [`SDRAM_EMU_HADDR_W-1:0] addr;
    logic [`SDRAM_EMU_DATA_W-1:0]  data;
    logic                          write;
    hsize_e                        size;
  } mon_rec_t;

endpackage

`default_nettype wire

//--- ahb_addr_phase.sv
// AHB-Lite address phase capture
//   Transfer acceptance from HSEL, HREADY and HTRANS
//   Alignment check against HSIZE
//   Byte lane enables
//   Array index through the bank/row/col remap

`default_nettype none

module ahb_addr_phase
  import sdram_emu_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     sysrst_n,
  input  wire ahb_req_t req_i,
  output dphase_t       dphase_o
);

  logic        accept;
  sdram_addr_u waddr;
  dphase_t     dphase_d;

  // Only NONSEQ and SEQ carry data, BUSY and IDLE are dropped
  assign accept = req_i.hsel && req_i.hready &&
                  (req_i.htrans == HTRANS_NONSEQ || req_i.htrans == HTRANS_SEQ);

  // Word address seen as linear and as bank/row/col
  assign waddr.linear = req_i.haddr[WADDR_W+1:2];

  ////////////////////////////////////////
  // Next data phase
  ////////////////////////////////////////

  always_comb
  begin
    dphase_d       = '0;
    dphase_d.valid = accept;
    dphase_d.write = req_i.hwrite;
    dphase_d.addr  = req_i.haddr;
    dphase_d.size  = req_i.hsize;
    // Row above bank, so consecutive bank groups interleave
    dphase_d.idx   = {waddr.brc.row, waddr.brc.bank, waddr.brc.col};

    case (req_i.hsize)
      HSIZE_BYTE:
      begin
        dphase_d.be = BE_W'(1) << req_i.haddr[1:0];
      end
      HSIZE_HALF:
      begin
        dphase_d.misaligned = req_i.haddr[0];
        dphase_d.be         = BE_W'(3) << {req_i.haddr[1], 1'b0};
      end
      HSIZE_WORD:
      begin
        dphase_d.misaligned = |req_i.haddr[1:0];
        dphase_d.be         = '1;
      end
      default:
      begin
        // Wider than the bus, refused like a misaligned access
        dphase_d.misaligned = 1'b1;
      end
    endcase

    // Refused access touches no lane
    if (dphase_d.misaligned)
      dphase_d.be = '0;
  end

  ////////////////////////////////////////
  // Data phase register
  ////////////////////////////////////////

  // Held while HREADY is low, reloaded on every ready cycle
  // No accept on a ready cycle leaves valid low
  always_ff @(posedge clk_i or negedge sysrst_n)
  begin
    if (!sysrst_n)
    begin
      dphase_o <= '0;
    end
    else if (req_i.hready)
    begin
      dphase_o <= dphase_d;
    end
  end

endmodule

`default_nettype wire

//--- ahb_wait_ctrl.sv
// Data phase sequencer of the SDRAM emulation slave
//   Wait state counter for OKAY transfers
//   Two-cycle ERROR response for refused transfers
//   Read issue one cycle ahead of completion
//   Completion and error strobes

`include "sdram_emu_settings.svh"

`default_nettype none

module ahb_wait_ctrl
  import sdram_emu_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    sysrst_n,
  input  wire dphase_t dphase_i,
  output logic         hreadyout_o,
  output logic         hresp_o,
  output logic         rd_en_o,
  output logic         done_o,
  output logic         err_o
);

  localparam int               CNT_W    = $clog2(`SDRAM_EMU_WAIT + 1);
  // Count value on the completing cycle
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SDRAM_EMU_WAIT);
  // Last wait cycle, array read issues here
  localparam logic [CNT_W-1:0] CNT_RD   = CNT_W'(`SDRAM_EMU_WAIT - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_ERR1,
    ST_ERR2
  } state_e;

  state_e           state_q;
  state_e           state_cur;
  state_e           state_d;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;

  ////////////////////////////////////////
  // State decode and outputs
  ////////////////////////////////////////

  always_comb
  begin
    // A fresh data phase shows up while idle, start it this cycle
    state_cur = state_q;
    if (state_q == ST_IDLE && dphase_i.valid)
      state_cur = dphase_i.misaligned ? ST_ERR1 : ST_WAIT;

    state_d     = state_cur;
    cnt_d       = cnt_q;
    hreadyout_o = 1'b1;
    hresp_o     = 1'b0;
    rd_en_o     = 1'b0;
    done_o      = 1'b0;
    err_o       = 1'b0;

    case (state_cur)
      ST_WAIT:
      begin
        if (cnt_q == CNT_LAST)
        begin
          // OKAY completion, HRDATA valid, HWDATA sampled
          done_o  = 1'b1;
          cnt_d   = '0;
          state_d = ST_IDLE;
        end
        else
        begin
          hreadyout_o = 1'b0;
          cnt_d       = cnt_q + 1'b1;
          rd_en_o     = !dphase_i.write && (cnt_q == CNT_RD);
        end
      end
      ST_ERR1:
      begin
        // First ERROR cycle stalls the master
        hreadyout_o = 1'b0;
        hresp_o     = 1'b1;
        state_d     = ST_ERR2;
      end
      ST_ERR2:
      begin
        hresp_o = 1'b1;
        err_o   = 1'b1;
        state_d = ST_IDLE;
      end
      default:
      begin
        // Idle, unselected or BUSY cycles, zero-wait OKAY
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge sysrst_n)
  begin
    if (!sysrst_n)
    begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

`default_nettype wire

//--- sram_array.sv
// Word storage of the SDRAM emulation slave
//   Array of one word per remapped index
//   Byte lane writes on the completion cycle
//   Registered read, issued one cycle before completion

`include "sdram_emu_settings.svh"

`default_nettype none

module sram_array
  import sdram_emu_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire dphase_t                      dphase_i,
  input  wire logic [`SDRAM_EMU_DATA_W-1:0] wdata_i,
  input  wire logic                         done_i,
  input  wire logic                         rd_en_i,
  output logic [`SDRAM_EMU_DATA_W-1:0]      rdata_o
);

  localparam int DEPTH = 2 ** WADDR_W;

  // One byte per lane in every word
  logic [BE_W-1:0][7:0] mem [DEPTH];

  ////////////////////////////////////////
  // Write and read ports
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    // Done only fires for OKAY transfers
    if (done_i && dphase_i.write)
    begin
      for (int b = 0; b < BE_W; b++)
      begin
        if (dphase_i.be[b])
          mem[dphase_i.idx][b] <= wdata_i[b*8 +: 8];
      end
    end

    // Whole word, the master picks its lanes
    if (rd_en_i)
    begin
      rdata_o <= mem[dphase_i.idx];
    end
  end

endmodule

`default_nettype wire

//--- access_monitor.sv
// Hardware access monitor
//   Window check on the byte address
//   Read and write counters of OKAY completions
//   Record of the last windowed access

`include "sdram_emu_settings.svh"

`default_nettype none

module access_monitor
  import sdram_emu_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         sysrst_n,
  input  wire dphase_t                      dphase_i,
  input  wire logic                         done_i,
  input  wire logic [`SDRAM_EMU_DATA_W-1:0] wdata_i,
  input  wire logic [`SDRAM_EMU_DATA_W-1:0] rdata_i,
  output logic [MON_CNT_W-1:0]              rd_cnt_o,
  output logic [MON_CNT_W-1:0]              wr_cnt_o,
  output mon_rec_t                          last_o
);

  logic in_win;
  logic hit;

  // Base inclusive, limit exclusive
  assign in_win = (dphase_i.addr >= `SDRAM_EMU_WIN_BASE) &&
                  (dphase_i.addr <  `SDRAM_EMU_WIN_LIMIT);

  // Error completions never raise done, so never counted
  assign hit = done_i && in_win;

  ////////////////////////////////////////
  // Counters
  ////////////////////////////////////////

  // Wrap at full scale
  always_ff @(posedge clk_i or negedge sysrst_n)
  begin
    if (!sysrst_n)
    begin
      rd_cnt_o <= '0;
      wr_cnt_o <= '0;
    end
    else if (hit)
    begin
      if (dphase_i.write)
        wr_cnt_o <= wr_cnt_o + 1'b1;
      else
        rd_cnt_o <= rd_cnt_o + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Last access record
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (hit)
    begin
      last_o.addr  <= dphase_i.addr;
      // Write data and read data both valid on the done cycle
      last_o.data  <= dphase_i.write ? wdata_i : rdata_i;
      last_o.write <= dphase_i.write;
      last_o.size  <= dphase_i.size;
    end
  end

endmodule

`default_nettype wire

//--- sdram_emu_top.sv
// AHB-Lite slave standing in for an off-chip SDRAM
//   Address phase capture
//   Wait state and response sequencer
//   Word array with byte lanes
//   Windowed access monitor

`include "sdram_emu_settings.svh"

`default_nettype none

module sdram_emu_top
  import sdram_emu_pkg::*;
(
  input  wire logic                         clk_i,
  input  wire logic                         sysrst_n,
  input  wire ahb_req_t                     req_i,
  input  wire logic [`SDRAM_EMU_DATA_W-1:0] hwdata_i,
  output ahb_rsp_t                          rsp_o,
  output logic [MON_CNT_W-1:0]              mon_rd_cnt_o,
  output logic [MON_CNT_W-1:0]              mon_wr_cnt_o,
  output mon_rec_t                          mon_last_o
);

  dphase_t                      dphase;
  logic                         hreadyout;
  logic                         hresp;
  logic                         rd_en;
  logic                         done;
  logic [`SDRAM_EMU_DATA_W-1:0] rdata;

  // Response bundle
  assign rsp_o.hrdata    = rdata;
  assign rsp_o.hreadyout = hreadyout;
  assign rsp_o.hresp     = hresp;

  ////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////

  ahb_addr_phase i_addr_phase (
    .clk_i    ( clk_i    ),
    .sysrst_n ( sysrst_n ),
    .req_i    ( req_i    ),
    .dphase_o ( dphase   )
  );

  ahb_wait_ctrl i_wait_ctrl (
    .clk_i       ( clk_i     ),
    .sysrst_n    ( sysrst_n  ),
    .dphase_i    ( dphase    ),
    .hreadyout_o ( hreadyout ),
    .hresp_o     ( hresp     ),
    .rd_en_o     ( rd_en     ),
    .done_o      ( done      ),
    .err_o       (           )
  );

  ////////////////////////////////////////
  // Storage and monitor
  ////////////////////////////////////////

  sram_array i_sram_array (
    .clk_i    ( clk_i    ),
    .dphase_i ( dphase   ),
    .wdata_i  ( hwdata_i ),
    .done_i   ( done     ),
    .rd_en_i  ( rd_en    ),
    .rdata_o  ( rdata    )
  );

  access_monitor i_access_monitor (
    .clk_i    ( clk_i        ),
    .sysrst_n ( sysrst_n     ),
    .dphase_i ( dphase       ),
    .done_i   ( done         ),
    .wdata_i  ( hwdata_i     ),
    .rdata_i  ( rdata        ),
    .rd_cnt_o ( mon_rd_cnt_o ),
    .wr_cnt_o ( mon_wr_cnt_o ),
    .last_o   ( mon_last_o   )
  );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// Testbench clock and reset source
//   20 ns clock
//   Active low reset held for 8 cycles

`default_nettype none

module tb_clk_gen
(
  output logic clk_o,
  output logic sysrst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RST_CYCLES = 8;

  // Free running, rising edges at 10, 30, 50 ns
  initial
  begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Released on a falling edge, away from the DUT sampling edge
  initial
  begin
    sysrst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    sysrst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_sdram_emu_properties.sv
// Protocol assertions on the slave response
//   Two-cycle ERROR response
//   Ready and OKAY out of reset
//   Bounded OKAY wait states
//   Bind onto the slave top level

`include "sdram_emu_settings.svh"

`default_nettype none

module tb_sdram_emu_properties
  import sdram_emu_pkg::*;
(
  input wire logic     clk_i,
  input wire logic     sysrst_n,
  input wire ahb_rsp_t rsp_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertion tally, read by the testbench top
  int unsigned fail_cnt = 0;
  int unsigned stall_cnt;

  // Consecutive OKAY stall cycles
  always_ff @(posedge clk_i or negedge sysrst_n)
  begin
    if (!sysrst_n)
      stall_cnt <= 0;
    else if (rsp_i.hreadyout || rsp_i.hresp)
      stall_cnt <= 0;
    else
      stall_cnt <= stall_cnt + 1;
  end

  ////////////////////////////////////////
  // ERROR response shape
  ////////////////////////////////////////

  // First cycle stalls, second completes
  a_err_first: assert property (@(posedge clk_i) disable iff (!sysrst_n)
    $rose(rsp_i.hresp) |-> !rsp_i.hreadyout ##1 (rsp_i.hresp && rsp_i.hreadyout))
  else
  begin
    fail_cnt++;
    $error("ERROR response did not complete on its second cycle");
  end

  // Completing ERROR cycle always follows the stalling one
  a_err_second: assert property (@(posedge clk_i) disable iff (!sysrst_n)
    (rsp_i.hresp && rsp_i.hreadyout) |-> $past(rsp_i.hresp && !rsp_i.hreadyout))
  else
  begin
    fail_cnt++;
    $error("ERROR completion without a stalling first cycle");
  end

  ////////////////////////////////////////
  // Reset and wait states
  ////////////////////////////////////////

  a_ready_after_reset: assert property (@(posedge clk_i)
    $rose(sysrst_n) |-> rsp_i.hreadyout && !rsp_i.hresp)
  else
  begin
    fail_cnt++;
    $error("Slave not ready with OKAY after reset");
  end

  a_wait_bound: assert property (@(posedge clk_i) disable iff (!sysrst_n)
    stall_cnt <= `SDRAM_EMU_WAIT)
  else
  begin
    fail_cnt++;
    $error("OKAY data phase stalled for more than the wait states");
  end

endmodule

bind sdram_emu_top tb_sdram_emu_properties i_props (
  .clk_i    ( clk_i    ),
  .sysrst_n ( sysrst_n ),
  .rsp_i    ( rsp_o    )
);

`default_nettype wire

//--- tb_sdram_emu.sv
// Testbench top of the SDRAM emulation slave
//   AHB-Lite master fed from the vector file
//   Response, latency and monitor checks
//   Reference model of the access monitor
//   Cycle limit on the whole run

`include "sdram_emu_settings.svh"

`default_nettype none

module tb_sdram_emu
  import sdram_emu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam string VEC_FILE = "tb_input_vectors.txt";

  // One transfer of the vector file
  typedef struct packed {
    logic [7:0]                    op;
    logic [`SDRAM_EMU_HADDR_W-1:0] addr;
    hsize_e                        size;
    logic [`SDRAM_EMU_DATA_W-1:0]  wdata;
    logic [`SDRAM_EMU_DATA_W-1:0]  rdata;
    logic                          resp;
  } vec_t;

  logic                         clk;
  logic                         sysrst_n;
  ahb_req_t                     req_drv;
  ahb_req_t                     req;
  logic [`SDRAM_EMU_DATA_W-1:0] hwdata;
  ahb_rsp_t                     rsp;
  logic [MON_CNT_W-1:0]         mon_rd_cnt;
  logic [MON_CNT_W-1:0]         mon_wr_cnt;
  mon_rec_t                     mon_last;

  vec_t        vecs [$];
  int unsigned err_cnt;
  int unsigned test_cnt;
  int unsigned test_fail_cnt;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;

  // Single slave drives HREADY from its own HREADYOUT
  always_comb
  begin
    req        = req_drv;
    req.hready = rsp.hreadyout;
  end

  tb_clk_gen i_clk_gen (
    .clk_o      ( clk      ),
    .sysrst_n_o ( sysrst_n )
  );

  sdram_emu_top i_sdram_emu_top (
    .clk_i        ( clk        ),
    .sysrst_n     ( sysrst_n   ),
    .req_i        ( req        ),
    .hwdata_i     ( hwdata     ),
    .rsp_o        ( rsp        ),
    .mon_rd_cnt_o ( mon_rd_cnt ),
    .mon_wr_cnt_o ( mon_wr_cnt ),
    .mon_last_o   ( mon_last   )
  );

  ////////////////////////////////////////
  // Cycle limit
  ////////////////////////////////////////

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, the vectors did not finish", cycle_cnt);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Vector file
  ////////////////////////////////////////

  task automatic read_vectors();
    int                            fd;
    int                            n;
    string                         line;
    logic [7:0]                    op;
    logic [`SDRAM_EMU_HADDR_W-1:0] addr;
    int                            size;
    logic [`SDRAM_EMU_DATA_W-1:0]  wdata;
    logic [`SDRAM_EMU_DATA_W-1:0]  rdata;
    int                            resp;
    vec_t                          v;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0)
    begin
      $display("Cannot open the vector file %s", VEC_FILE);
      err_cnt++;
      return;
    end
    while ($fgets(line, fd) > 0)
    begin
      // Skip column notes and blank lines
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      n = $sscanf(line, "%c %h %d %h %h %d", op, addr, size, wdata, rdata, resp);
      if (n != 6)
      begin
        $display("Malformed vector line: %s", line);
        err_cnt++;
        continue;
      end
      v.op    = op;
      v.addr  = addr;
      v.size  = hsize_e'(size);
      v.wdata = wdata;
      v.rdata = rdata;
      v.resp  = resp[0];
      vecs.push_back(v);
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // Bus master
  ////////////////////////////////////////

  // Address phase, then the data phase until HREADYOUT
  task automatic run_transfer(input vec_t v, output ahb_rsp_t got, output int cycles);
    @(posedge clk);
    req_drv.hsel   <= 1'b1;
    req_drv.haddr  <= v.addr;
    req_drv.hwrite <= (v.op == "W");
    req_drv.hsize  <= v.size;
    if (v.op == "I")
      req_drv.htrans <= HTRANS_IDLE;
    else
      req_drv.htrans <= HTRANS_NONSEQ;
    // Accepted on this edge since the idle bus keeps HREADY high
    @(posedge clk);
    req_drv.hsel   <= 1'b0;
    req_drv.htrans <= HTRANS_IDLE;
    hwdata         <= v.wdata;
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (!rsp.hreadyout && cycles < 16);
    got = rsp;
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_rsp(input ahb_rsp_t got, input ahb_rsp_t exp, input bit cmp_data);
    if (got.hreadyout !== exp.hreadyout)
    begin
      $display("FAIL t=%0t hreadyout got %0b exp %0b", $time, got.hreadyout, exp.hreadyout);
      err_cnt++;
    end
    if (got.hresp !== exp.hresp)
    begin
      $display("FAIL t=%0t hresp got %0b exp %0b", $time, got.hresp, exp.hresp);
      err_cnt++;
    end
    if (cmp_data && got.hrdata !== exp.hrdata)
    begin
      $display("FAIL t=%0t hrdata got %h exp %h", $time, got.hrdata, exp.hrdata);
      err_cnt++;
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp)
    begin
      $display("FAIL t=%0t data phase cycles got %0d exp %0d", $time, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_mon_cnt(input logic [MON_CNT_W-1:0] got,
                               input logic [MON_CNT_W-1:0] exp, input string name);
    if (got !== exp)
    begin
      $display("FAIL t=%0t %s got %0d exp %0d", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // Fields shown as addr/data/write/size
  task automatic check_mon_rec(input mon_rec_t got, input mon_rec_t exp);
    if (got !== exp)
    begin
      $display("FAIL t=%0t mon_last_o got %h/%h/%0b/%0d exp %h/%h/%0b/%0d", $time,
               got.addr, got.data, got.write, got.size,
               exp.addr, exp.data, exp.write, exp.size);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    test_cnt++;
    if (err_cnt != errs_before)
    begin
      test_fail_cnt++;
      $display("test %0d %s: failed", test_cnt, name);
    end
    else
    begin
      $display("test %0d %s: ok", test_cnt, name);
    end
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial
  begin
    ahb_rsp_t    exp;
    ahb_rsp_t    got;
    mon_rec_t    exp_rec;
    int          cycles;
    int          exp_cycles;
    int unsigned exp_rd;
    int unsigned exp_wr;
    int unsigned errs_before;
    bit          in_win;

    req_drv       = '0;
    hwdata        = '0;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    cycle_cnt     = 0;
    exp_rd        = 0;
    exp_wr        = 0;
    exp_rec       = '0;
    read_vectors();
    cycle_limit = vecs.size() * 6 + 40;

    // Idle slave and cleared counters out of reset
    @(posedge sysrst_n);
    @(negedge clk);
    errs_before   = err_cnt;
    exp           = '0;
    exp.hreadyout = 1'b1;
    check_rsp(rsp, exp, 1'b0);
    check_mon_cnt(mon_rd_cnt, '0, "mon_rd_cnt_o");
    check_mon_cnt(mon_wr_cnt, '0, "mon_wr_cnt_o");
    report_test("reset state", errs_before);

    foreach (vecs[i])
    begin
      errs_before = err_cnt;
      run_transfer(vecs[i], got, cycles);
      exp.hrdata    = vecs[i].rdata;
      exp.hreadyout = 1'b1;
      exp.hresp     = vecs[i].resp;
      // Zero wait for IDLE and two cycles for ERROR
      if (vecs[i].op == "I")
        exp_cycles = 1;
      else if (vecs[i].resp)
        exp_cycles = 2;
      else
        exp_cycles = `SDRAM_EMU_WAIT + 1;
      check_rsp(got, exp, vecs[i].op == "R" && !vecs[i].resp);
      check_latency(cycles, exp_cycles);

      // Monitor model counts OKAY transfers inside the window
      in_win = (vecs[i].addr >= `SDRAM_EMU_WIN_BASE) &&
               (vecs[i].addr < `SDRAM_EMU_WIN_LIMIT);
      if (vecs[i].op != "I" && !vecs[i].resp && in_win)
      begin
        if (vecs[i].op == "W")
          exp_wr++;
        else
          exp_rd++;
        exp_rec.addr  = vecs[i].addr;
        exp_rec.data  = (vecs[i].op == "W") ? vecs[i].wdata : vecs[i].rdata;
        exp_rec.write = (vecs[i].op == "W");
        exp_rec.size  = vecs[i].size;
      end
      report_test($sformatf("%c %h size %0d", vecs[i].op, vecs[i].addr, vecs[i].size),
                  errs_before);
    end

    // Monitor lags completion by one cycle
    repeat (2) @(posedge clk);
    @(negedge clk);
    errs_before = err_cnt;
    check_mon_cnt(mon_rd_cnt, MON_CNT_W'(exp_rd), "mon_rd_cnt_o");
    check_mon_cnt(mon_wr_cnt, MON_CNT_W'(exp_wr), "mon_wr_cnt_o");
    check_mon_rec(mon_last, exp_rec);
    report_test("access monitor", errs_before);

    errs_before = err_cnt;
    if (i_sdram_emu_top.i_props.fail_cnt != 0)
    begin
      $display("Protocol assertions failed %0d times", i_sdram_emu_top.i_props.fail_cnt);
      err_cnt++;
    end
    report_test("protocol assertions", errs_before);

    $display("Tests run %0d, failed %0d, errors %0d", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_input_vectors.txt
# op addr size wdata exp_rdata exp_resp
# op R/W/I, hex addr and data, size 0 byte 1 half 2 word, resp 0 OKAY 1 ERROR
W 004 2 11111111 00000000 0
W 404 2 22222222 00000000 0
W 804 2 33333333 00000000 0
W C04 2 44444444 00000000 0
R 004 2 00000000 11111111 0
R 404 2 00000000 22222222 0
R 804 2 00000000 33333333 0
R C04 2 00000000 44444444 0
I 000 0 00000000 00000000 0
W 500 2 a5a5a5a5 00000000 0
W 501 0 0000c300 00000000 0
W 502 1 5a5a0000 00000000 0
R 500 2 00000000 5a5ac3a5 0
W 503 0 7e000000 00000000 0
R 500 2 00000000 7e5ac3a5 0
W 502 2 ffffffff 00000000 1
W 501 1 12341234 00000000 1
R 500 2 00000000 7e5ac3a5 0
R 805 1 00000000 00000000 1
I 000 0 00000000 00000000 0
R 804 2 00000000 33333333 0
W 004 1 0000beef 00000000 0
R 004 2 00000000 1111beef 0

//--- flist.f
+incdir+.
sdram_emu_pkg.sv
ahb_addr_phase.sv
ahb_wait_ctrl.sv
sram_array.sv
access_monitor.sv
sdram_emu_top.sv
tb_clk_gen.sv
tb_sdram_emu_properties.sv
tb_sdram_emu.sv

//--- Bender.yml
package:
  name: sdram_emu

sources:
  - include_dirs:
      - .
    files:
      - sdram_emu_pkg.sv
      - ahb_addr_phase.sv
      - ahb_wait_ctrl.sv
      - sram_array.sv
      - access_monitor.sv
      - sdram_emu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_sdram_emu_properties.sv
      - tb_sdram_emu.sv
